/* source/rf_pg_pkg.sv */
//--------------------------------------------------------------------
// Shared types and constants for the power-gated 16x23 register file
// and its power-gating sequencer
//--------------------------------------------------------------------

package rf_pg_pkg;

    //--------------------------------------------------------------------
    // Sizes and sequencing intervals
    //--------------------------------------------------------------------

    // Number of entries in the array
    localparam int RF_DEPTH = 16;
    // Cycles spent isolated before the supply is removed
    localparam int ISO_CYCLES = 2;
    // Cycles spent waking before isolation is released
    localparam int WAKE_CYCLES = 4;
    // Power-enable ripple through the array, must not exceed WAKE_CYCLES
    localparam int PWR_CHAIN_CYCLES = 2;
    // Width of the interval timer count
    localparam int TIMER_W = 3;

    // Entry address
    typedef logic [3:0] rf_addr_t;
    // Logical data word seen by the client
    typedef logic [22:0] rf_data_t;
    // Physical word held by the macro, top bit is the pad
    typedef logic [23:0] rf_word_t;

    // Sequencer states
    typedef enum logic [1:0] {
        PG_ON      = 2'd0,
        PG_ISOLATE = 2'd1,
        PG_OFF     = 2'd2,
        PG_WAKE    = 2'd3
    } pg_state_t;

    //--------------------------------------------------------------------
    // Request and control bundles
    //--------------------------------------------------------------------

    // Client write strobe, one cycle wide
    typedef struct packed {
        logic     en;
        rf_addr_t addr;
        rf_data_t data;
    } rf_wr_req_t;

    // Client read strobe, one cycle wide
    typedef struct packed {
        logic     en;
        rf_addr_t addr;
    } rf_rd_req_t;

    // Write as the macro sees it, data already padded to the physical width
    typedef struct packed {
        logic     en;
        rf_addr_t addr;
        rf_word_t word;
    } rf_wr_word_t;

    // Isolation and power-enable controls from the sequencer
    typedef struct packed {
        logic isol_en;
        logic pwr_enable_b;
    } pg_ctl_t;

endpackage

/* source/mem_reset_sync.sv */
//--------------------------------------------------------------------
// Memory reset synchronizer with scan bypass
//--------------------------------------------------------------------

module mem_reset_sync (
    input  logic clk,
    input  logic rst_n,
    input  logic fscan_rstbypen,
    input  logic fscan_byprst_b,
    output logic rst_n_sync
);

    // Two-stage shift of a constant one, cleared asynchronously
    logic [1:0] sync_q;

    // Assertion is immediate, release waits for two rising edges
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sync_q <= 2'b00;
        end else begin
            sync_q <= {sync_q[0], 1'b1};
        end
    end

    // Under scan the tester owns the memory reset directly
    assign rst_n_sync = fscan_rstbypen ? fscan_byprst_b : sync_q[1];

endmodule

/* source/rf_array_16x24.sv */
//--------------------------------------------------------------------
// Behavioral 16x24 register file macro with registered read,
// output isolation clamp and a power-enable ripple chain
//--------------------------------------------------------------------

module rf_array_16x24 (
    input  logic                  clk,
    input  logic                  rst_n,
    input  rf_pg_pkg::rf_wr_word_t wr,
    input  rf_pg_pkg::rf_rd_req_t  rd,
    input  rf_pg_pkg::pg_ctl_t     ctl,
    output rf_pg_pkg::rf_word_t    rdata,
    output logic                  rvalid,
    output logic                  pwr_enable_b_out
);

    import rf_pg_pkg::*;

    // Storage and per-entry valid bits
    rf_word_t              mem [RF_DEPTH];
    logic [RF_DEPTH-1:0]   valid_q;

    // Power-enable as it ripples through the macro's sleep transistors
    logic [PWR_CHAIN_CYCLES-1:0] pwr_chain_q;

    // Read pipeline register
    rf_word_t rd_word_q;
    logic     rd_valid_q;

    // Accesses only land while the supply is up at both ends and outputs are live
    logic access_ok;
    logic wr_ok;
    logic rd_ok;

    assign access_ok = !ctl.isol_en && !ctl.pwr_enable_b && !pwr_enable_b_out;
    assign wr_ok     = wr.en && access_ok;
    assign rd_ok     = rd.en && access_ok;

    //--------------------------------------------------------------------
    // Power-enable chain
    //--------------------------------------------------------------------

    // Resets to powered, the sequencer also comes out of reset powered
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pwr_chain_q <= '0;
        end else begin
            pwr_chain_q[0] <= ctl.pwr_enable_b;
            for (int i = 1; i < PWR_CHAIN_CYCLES; i++) begin
                pwr_chain_q[i] <= pwr_chain_q[i-1];
            end
        end
    end

    assign pwr_enable_b_out = pwr_chain_q[PWR_CHAIN_CYCLES-1];

    //--------------------------------------------------------------------
    // Storage
    //--------------------------------------------------------------------

    // Data cells hold whatever was last written, valid bits decide what is seen
    always_ff @(posedge clk) begin
        if (wr_ok) begin
            mem[wr.addr] <= wr.word;
        end
    end

    // Contents are lost for as long as the far end of the chain shows power off
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else if (pwr_enable_b_out) begin
            valid_q <= '0;
        end else if (wr_ok) begin
            valid_q[wr.addr] <= 1'b1;
        end
    end

    // Registered read, a same-cycle write to the address is not visible yet
    always_ff @(posedge clk) begin
        if (rd_ok) begin
            rd_word_q <= valid_q[rd.addr] ? mem[rd.addr] : '0;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_valid_q <= 1'b0;
        end else begin
            rd_valid_q <= rd_ok;
        end
    end

    // Isolation forces the outputs low so nothing floats toward the client
    assign rdata  = ctl.isol_en ? '0 : rd_word_q;
    assign rvalid = rd_valid_q && !ctl.isol_en;

endmodule

/* source/rf_pg_16x23.sv */
//--------------------------------------------------------------------
// Power-gated 16x23 register file wrapper around the 16x24 macro
//--------------------------------------------------------------------

module rf_pg_16x23 (
    input  logic                 clk,
    input  logic                 ip_reset_b,
    input  logic                 fscan_rstbypen,
    input  logic                 fscan_byprst_b,
    input  rf_pg_pkg::rf_wr_req_t wr,
    input  rf_pg_pkg::rf_rd_req_t rd,
    input  rf_pg_pkg::pg_ctl_t    ctl,
    output rf_pg_pkg::rf_data_t   rdata,
    output logic                 rvalid,
    output logic                 pwr_enable_b_out
);

    import rf_pg_pkg::*;

    logic        ip_reset_b_sync;
    rf_wr_word_t wr_word;
    rf_word_t    rdata_word;

    // The macro's reset must release cleanly on the clock it runs on
    mem_reset_sync u_ip_reset_b_sync (
        .clk            (clk),
        .rst_n          (ip_reset_b),
        .fscan_rstbypen (fscan_rstbypen),
        .fscan_byprst_b (fscan_byprst_b),
        .rst_n_sync     (ip_reset_b_sync)
    );

    // The physical word is one bit wider, the pad is always written as zero
    assign wr_word.en   = wr.en;
    assign wr_word.addr = wr.addr;
    assign wr_word.word = {1'b0, wr.data};

    rf_array_16x24 u_rf (
        .clk              (clk),
        .rst_n            (ip_reset_b_sync),
        .wr               (wr_word),
        .rd               (rd),
        .ctl              (ctl),
        .rdata            (rdata_word),
        .rvalid           (rvalid),
        .pwr_enable_b_out (pwr_enable_b_out)
    );

    // Drop the pad on the way out
    assign rdata = rdata_word[22:0];

endmodule

/* source/pg_timer.sv */
//--------------------------------------------------------------------
// Loadable down-counter for the isolation and wake intervals
//--------------------------------------------------------------------

module pg_timer (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          timer_load,
    input  logic [rf_pg_pkg::TIMER_W-1:0] timer_cycles,
    output logic                          timer_done
);

    import rf_pg_pkg::*;

    logic [TIMER_W-1:0] count_q;

    // A load wins over the decrement, the count rests at zero
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count_q <= '0;
        end else if (timer_load) begin
            count_q <= timer_cycles;
        end else if (count_q != '0) begin
            count_q <= count_q - 1'b1;
        end
    end

    // Idle after reset, and never done in the cycle a new interval is loaded
    assign timer_done = (count_q == '0) && !timer_load;

endmodule

/* source/pg_ctrl_fsm.sv */
//--------------------------------------------------------------------
// Power-gating sequencer for the register file
// Isolates, removes power, restores power and deisolates on request
//--------------------------------------------------------------------

module pg_ctrl_fsm (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          sleep_req,
    input  logic                          wake_req,
    input  logic                          timer_done,
    input  logic                          pwr_enable_b_out,
    output logic                          timer_load,
    output logic [rf_pg_pkg::TIMER_W-1:0] timer_cycles,
    output rf_pg_pkg::pg_ctl_t             ctl,
    output logic                          pg_ready,
    output logic                          pg_asleep
);

    import rf_pg_pkg::*;

    pg_state_t state_q;
    pg_state_t state_d;

    //--------------------------------------------------------------------
    // Next state and timer loads
    //--------------------------------------------------------------------

    // The timer is loaded one short of the interval because it counts
    // down to zero and the state moves on the edge after done appears
    always_comb begin
        state_d      = state_q;
        timer_load   = 1'b0;
        timer_cycles = '0;
        case (state_q)
            PG_ON: begin
                // Sleep is only honored from the fully powered state
                if (sleep_req) begin
                    state_d      = PG_ISOLATE;
                    timer_load   = 1'b1;
                    timer_cycles = TIMER_W'(ISO_CYCLES - 1);
                end
            end
            PG_ISOLATE: begin
                // Outputs are clamped, let them settle before cutting supply
                if (timer_done) begin
                    state_d = PG_OFF;
                end
            end
            PG_OFF: begin
                if (wake_req) begin
                    state_d      = PG_WAKE;
                    timer_load   = 1'b1;
                    timer_cycles = TIMER_W'(WAKE_CYCLES - 1);
                end
            end
            PG_WAKE: begin
                // Both the interval and the macro's own power-good are needed
                if (timer_done && !pwr_enable_b_out) begin
                    state_d = PG_ON;
                end
            end
            default: begin
                state_d = PG_ON;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= PG_ON;
        end else begin
            state_q <= state_d;
        end
    end

    //--------------------------------------------------------------------
    // Controls to the macro and status to the client
    //--------------------------------------------------------------------

    // Isolation covers every state but PG_ON
    assign ctl.isol_en = (state_q != PG_ON);

    // Supply is only removed in PG_OFF, it comes back as soon as PG_WAKE starts
    assign ctl.pwr_enable_b = (state_q == PG_OFF);

    assign pg_ready  = (state_q == PG_ON);
    assign pg_asleep = (state_q == PG_OFF);

endmodule

/* source/rf_pg_subsys.sv */
//--------------------------------------------------------------------
// Power-gated register file subsystem
// Sequencer, interval timer and the 16x23 register file
//--------------------------------------------------------------------

module rf_pg_subsys (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 ip_reset_b,
    input  logic                 fscan_rstbypen,
    input  logic                 fscan_byprst_b,
    input  rf_pg_pkg::rf_wr_req_t wr_req,
    input  rf_pg_pkg::rf_rd_req_t rd_req,
    input  logic                 sleep_req,
    input  logic                 wake_req,
    output rf_pg_pkg::rf_data_t   rdata,
    output logic                 rvalid,
    output logic                 pg_ready,
    output logic                 pg_asleep
);

    import rf_pg_pkg::*;

    // Sequencer to macro
    pg_ctl_t            pg_ctl;
    logic               pwr_enable_b_out;

    // Sequencer to timer and back
    logic               timer_load;
    logic [TIMER_W-1:0] timer_cycles;
    logic               timer_done;

    pg_ctrl_fsm u_pg_ctrl_fsm (
        .clk              (clk),
        .rst_n            (rst_n),
        .sleep_req        (sleep_req),
        .wake_req         (wake_req),
        .timer_done       (timer_done),
        .pwr_enable_b_out (pwr_enable_b_out),
        .timer_load       (timer_load),
        .timer_cycles     (timer_cycles),
        .ctl              (pg_ctl),
        .pg_ready         (pg_ready),
        .pg_asleep        (pg_asleep)
    );

    pg_timer u_pg_timer (
        .clk          (clk),
        .rst_n        (rst_n),
        .timer_load   (timer_load),
        .timer_cycles (timer_cycles),
        .timer_done   (timer_done)
    );

    // Client requests go straight in, the macro drops what it cannot take
    rf_pg_16x23 u_rf_pg_16x23 (
        .clk              (clk),
        .ip_reset_b       (ip_reset_b),
        .fscan_rstbypen   (fscan_rstbypen),
        .fscan_byprst_b   (fscan_byprst_b),
        .wr               (wr_req),
        .rd               (rd_req),
        .ctl              (pg_ctl),
        .rdata            (rdata),
        .rvalid           (rvalid),
        .pwr_enable_b_out (pwr_enable_b_out)
    );

endmodule

/* sim/rf_pg_checker.sv */
//--------------------------------------------------------------------
// Reference model of the register file and read data comparison
//--------------------------------------------------------------------

module rf_pg_checker (
    input  logic                  clk,
    input  logic                  rst_n,
    input  rf_pg_pkg::rf_wr_req_t wr_req,
    input  rf_pg_pkg::rf_rd_req_t rd_req,
    input  rf_pg_pkg::rf_data_t   rdata,
    input  logic                  rvalid,
    input  logic                  pg_ready,
    input  logic                  pg_asleep,
    output int                    errors
);
    timeunit 1ns;
    timeprecision 1ps;
    import rf_pg_pkg::*;

    // Expected contents, wiped whenever the supply is cut
    rf_data_t model [RF_DEPTH];
    // Result expected on the next rising edge
    logic     exp_valid;
    rf_data_t exp_data;

    initial begin
        errors = 0;
    end

    // Outputs are compared first, then this edge's requests update the model
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            exp_valid = 1'b0;
            exp_data  = '0;
            for (int i = 0; i < RF_DEPTH; i++) begin
                model[i] = '0;
            end
        end else begin
            if (rvalid !== exp_valid || (exp_valid && rdata !== exp_data)) begin
                $display("Error: %0t read gave valid %b data %h, expected valid %b data %h",
                         $time, rvalid, rdata, exp_valid, exp_data);
                errors++;
            end
            // Only PG_ON takes requests, and a read sees the entry before a same-cycle write
            exp_valid = rd_req.en && pg_ready;
            exp_data  = model[rd_req.addr];
            if (pg_asleep) begin
                for (int i = 0; i < RF_DEPTH; i++) begin
                    model[i] = '0;
                end
            end else if (wr_req.en && pg_ready) begin
                model[wr_req.addr] = wr_req.data;
            end
        end
    end

endmodule

/* sim/rf_pg_assertions.sv */
//--------------------------------------------------------------------
// Bound checks on sequencer status and register file read validity
//--------------------------------------------------------------------

module rf_pg_assertions #(
    // Sequencer status checks when set, read clamp check otherwise
    parameter bit SEQ_CHECKS = 1'b1
) (
    input logic clk,
    input logic rst_n,
    input logic ready,
    input logic asleep,
    input logic wake,
    input logic isol,
    input logic rvalid
);
    timeunit 1ns;
    timeprecision 1ps;
    import rf_pg_pkg::*;

    // Number of failed assertions, summed up by the testbench at the end
    int fail_count = 0;

    if (SEQ_CHECKS) begin : g_seq
        // Ready and asleep mark two different sequencer states
        assert property (@(posedge clk) disable iff (!rst_n) !(ready && asleep))
            else begin
                $error("pg_ready and pg_asleep are high together");
                fail_count++;
            end

        // A wake taken in PG_OFF keeps ready low for the wake interval, then raises it
        assert property (@(posedge clk) disable iff (!rst_n)
            (wake && asleep) |=> !ready [*WAKE_CYCLES] ##1 ready)
            else begin
                $error("pg_ready did not return WAKE_CYCLES after a wake");
                fail_count++;
            end
    end else begin : g_read
        // The clamp still holds for the cycle after any isolated cycle
        assert property (@(posedge clk) disable iff (!rst_n) isol |=> !rvalid)
            else begin
                $error("rvalid high right after an isolated cycle");
                fail_count++;
            end
    end

endmodule

// Sequencer side, status exclusivity and wake timing
bind pg_ctrl_fsm rf_pg_assertions #(.SEQ_CHECKS(1'b1)) u_fsm_assertions (
    .clk(clk), .rst_n(rst_n), .ready(pg_ready), .asleep(pg_asleep),
    .wake(wake_req), .isol(ctl.isol_en), .rvalid(1'b0)
);

// Macro side, only the isolation clamp applies
bind rf_array_16x24 rf_pg_assertions #(.SEQ_CHECKS(1'b0)) u_array_assertions (
    .clk(clk), .rst_n(rst_n), .ready(1'b0), .asleep(1'b0),
    .wake(1'b0), .isol(ctl.isol_en), .rvalid(rvalid)
);

/* sim/rf_pg_subsys_tb.sv */
//--------------------------------------------------------------------
// Testbench for the power-gated register file subsystem
//--------------------------------------------------------------------

module rf_pg_subsys_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import rf_pg_pkg::*;

    logic        clk;
    logic        rst_n;
    logic        ip_reset_b;
    logic        sleep_req;
    logic        wake_req;
    rf_wr_req_t  wr_req;
    rf_rd_req_t  rd_req;
    rf_data_t    rdata;
    logic        rvalid;
    logic        pg_ready;
    logic        pg_asleep;
    logic [31:0] lfsr_q;
    int          tb_errors;
    int          chk_errors;
    int          asrt_errors;
    int          tests_done;

    always #5 clk = ~clk;

    // Scan inputs held at their functional values
    rf_pg_subsys u_rf_pg_subsys (
        .clk(clk), .rst_n(rst_n), .ip_reset_b(ip_reset_b),
        .fscan_rstbypen(1'b0), .fscan_byprst_b(1'b1),
        .wr_req(wr_req), .rd_req(rd_req), .sleep_req(sleep_req), .wake_req(wake_req),
        .rdata(rdata), .rvalid(rvalid), .pg_ready(pg_ready), .pg_asleep(pg_asleep)
    );

    rf_pg_checker u_rf_pg_checker (
        .clk, .rst_n, .wr_req, .rd_req, .rdata, .rvalid, .pg_ready, .pg_asleep,
        .errors(chk_errors)
    );

    // Galois LFSR, stepped once for every random bit handed out
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_q[0] ? (lfsr_q >> 1) ^ 32'h8020_0003 : lfsr_q >> 1;
            v = {v[30:0], lfsr_q[0]};
        end
        return v;
    endfunction

    // One cycle of client requests, applied on the falling edge, write data always random
    task automatic drive(input logic wr_en, input rf_addr_t wr_addr, input logic rd_en,
                         input rf_addr_t rd_addr, input logic sleep, input logic wake);
        @(negedge clk);
        wr_req    = '{en: wr_en, addr: wr_addr, data: rf_data_t'(rand_bits(23))};
        rd_req    = '{en: rd_en, addr: rd_addr};
        sleep_req = sleep;
        wake_req  = wake;
    endtask

    task automatic idle(input int count);
        repeat (count) drive(1'b0, '0, 1'b0, '0, 1'b0, 1'b0);
    endtask

    // Mostly reads, so back-to-back reads come up often
    task automatic random_cycles(input int count);
        repeat (count) begin
            drive(rand_bits(1) != 0, rf_addr_t'(rand_bits(4)),
                  rand_bits(2) != 0, rf_addr_t'(rand_bits(4)), 1'b0, 1'b0);
        end
    endtask

    task automatic read_all();
        for (int a = 0; a < RF_DEPTH; a++) begin
            drive(1'b0, '0, 1'b1, rf_addr_t'(a), 1'b0, 1'b0);
        end
        idle(2);
    endtask

    // Reads random addresses until pg_asleep or pg_ready is high, counting falling edges
    task automatic wait_flag(input logic want_asleep, input int limit, output int cycles);
        cycles = 0;
        while ((want_asleep ? pg_asleep : pg_ready) !== 1'b1 && cycles < limit) begin
            drive(1'b0, '0, 1'b1, rf_addr_t'(rand_bits(4)), 1'b0, 1'b0);
            cycles++;
        end
        if ((want_asleep ? pg_asleep : pg_ready) !== 1'b1) begin
            $display("Timed out: %s did not rise within %0d cycles",
                     want_asleep ? "pg_asleep" : "pg_ready", limit);
            tb_errors++;
        end
    endtask

    task automatic end_test(input string name);
        asrt_errors = u_rf_pg_subsys.u_pg_ctrl_fsm.u_fsm_assertions.fail_count
                    + u_rf_pg_subsys.u_rf_pg_16x23.u_rf.u_array_assertions.fail_count;
        tests_done++;
        $display("Test %0d %s finished, %0d errors so far", tests_done, name,
                 tb_errors + chk_errors + asrt_errors);
    endtask

    initial begin
        int n;
        $timeformat(-9, 0, " ns", 0);
        lfsr_q      = 32'hb528;
        tb_errors   = 0;
        asrt_errors = 0;
        tests_done  = 0;
        clk         = 1'b0;
        rst_n       = 1'b0;
        ip_reset_b  = 1'b0;
        sleep_req   = 1'b0;
        wake_req    = 1'b0;
        wr_req      = '0;
        rd_req      = '0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n      = 1'b1;
        ip_reset_b = 1'b1;
        // The memory reset needs two more edges to release
        idle(4);

        read_all();
        end_test("reset contents");

        // Filling every entry reads the same address in the same cycle
        for (int a = 0; a < RF_DEPTH; a++) begin
            drive(1'b1, rf_addr_t'(a), 1'b1, rf_addr_t'(a), 1'b0, 1'b0);
        end
        random_cycles(48);
        idle(2);
        end_test("random writes and reads");

        drive(1'b0, '0, 1'b0, '0, 1'b1, 1'b0);
        random_cycles(1);
        if (pg_ready !== 1'b0) begin
            $display("The sleep strobe did not lower pg_ready on the edge that took it");
            tb_errors++;
        end
        random_cycles(2);
        wait_flag(1'b1, 10, n);
        random_cycles(4);
        end_test("sleep with blocked requests");

        drive(1'b0, '0, 1'b0, '0, 1'b0, 1'b1);
        wait_flag(1'b0, 20, n);
        // The first falling edge counted already follows the edge that took the wake
        if (n - 1 != WAKE_CYCLES) begin
            $display("Error: %0t pg_ready returned %0d cycles after the wake, expected %0d",
                     $time, n - 1, WAKE_CYCLES);
            tb_errors++;
        end
        read_all();
        end_test("wake and lost contents");

        for (int a = 0; a < RF_DEPTH; a++) begin
            drive(1'b1, rf_addr_t'(a), 1'b0, '0, 1'b0, 1'b0);
        end
        repeat (3) drive(1'b0, '0, 1'b0, '0, 1'b0, 1'b1);
        idle(1);
        if (pg_ready !== 1'b1) begin
            $display("A wake strobe while powered dropped pg_ready");
            tb_errors++;
        end
        read_all();
        // Wake during isolation and sleep while off must both be ignored
        drive(1'b0, '0, 1'b0, '0, 1'b1, 1'b0);
        drive(1'b0, '0, 1'b0, '0, 1'b0, 1'b1);
        wait_flag(1'b1, 10, n);
        repeat (3) drive(1'b0, '0, 1'b0, '0, 1'b1, 1'b0);
        idle(1);
        if (pg_asleep !== 1'b1) begin
            $display("A sleep strobe while powered off moved the sequencer out of PG_OFF");
            tb_errors++;
        end
        drive(1'b0, '0, 1'b0, '0, 1'b0, 1'b1);
        wait_flag(1'b0, 20, n);
        idle(2);
        end_test("ignored strobes");

        $display("%0d tests run, %0d checker errors, %0d testbench errors, %0d assertion errors",
                 tests_done, chk_errors, tb_errors, asrt_errors);
        if (tb_errors == 0 && chk_errors == 0 && asrt_errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

/* rf_pg_subsys.f */
source/rf_pg_pkg.sv
source/mem_reset_sync.sv
source/rf_array_16x24.sv
source/rf_pg_16x23.sv
source/pg_timer.sv
source/pg_ctrl_fsm.sv
source/rf_pg_subsys.sv
sim/rf_pg_checker.sv
sim/rf_pg_assertions.sv
sim/rf_pg_subsys_tb.sv
